/* verilog/vga_timing_pkg.sv */
package vga_timing_pkg;

  // reduced panel mode, small enough to simulate whole frames
  // horizontal, in pixels
  localparam int h_visible     = 8;
  localparam int h_front_porch = 2;
  localparam int h_sync_pulse  = 3;
  localparam int h_back_porch  = 3;
  localparam int h_whole_line  = h_visible + h_front_porch + h_sync_pulse + h_back_porch;

  // vertical, in lines
  localparam int v_visible     = 4;
  localparam int v_front_porch = 1;
  localparam int v_sync_pulse  = 1;
  localparam int v_back_porch  = 1;
  localparam int v_whole_frame = v_visible + v_front_porch + v_sync_pulse + v_back_porch;

  // sync windows, sync is driven low for start <= pos < end
  localparam int h_sync_start = h_visible + h_front_porch;
  localparam int h_sync_end   = h_sync_start + h_sync_pulse;
  localparam int v_sync_start = v_visible + v_front_porch;
  localparam int v_sync_end   = v_sync_start + v_sync_pulse;

  // raster counter widths
  localparam int col_width = $clog2(h_whole_line);
  localparam int row_width = $clog2(v_whole_frame);

  // system clocks per output pixel
  localparam int scan_div = 2;

endpackage

/* verilog/framebuf_pkg.sv */
package framebuf_pkg;

  // one word per visible pixel, 8 x 4 panel
  localparam int fb_addr_width = 5;
  localparam int fb_data_width = 16;
  localparam int fb_depth      = 32;

  // colour nibble positions inside a framebuffer word
  // bits 3..0 are spare
  localparam int color_width = 4;
  localparam int red_lsb     = 12;
  localparam int green_lsb   = 8;
  localparam int blue_lsb    = 4;

  // one pixel as it travels to the panel
  typedef struct packed {
    logic [color_width-1:0] red;
    logic [color_width-1:0] green;
    logic [color_width-1:0] blue;
    logic                   hsync;
    logic                   vsync;
  } pixel_t;

  // axi response codes
  localparam logic [1:0] resp_okay = 2'b00;

endpackage

/* verilog/axil_read_if.sv */
interface axil_read_if (
  input logic clk
);
  import framebuf_pkg::*;

  // read address channel
  logic [fb_addr_width-1:0] araddr;
  logic                     arvalid;
  logic                     arready;

  // read data channel
  logic [fb_data_width-1:0] rdata;
  logic [1:0]               rresp;
  logic                     rvalid;
  logic                     rready;

  // requester side, the pixel stream
  modport master (
    input  clk, arready, rdata, rresp, rvalid,
    output araddr, arvalid, rready
  );

  // responder side, the framebuffer
  modport slave (
    input  clk, araddr, arvalid, rready,
    output arready, rdata, rresp, rvalid
  );

endinterface

/* verilog/framebuf_sram.sv */
module framebuf_sram (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   fb_we,
  input  logic [framebuf_pkg::fb_addr_width-1:0] fb_waddr,
  input  logic [framebuf_pkg::fb_data_width-1:0] fb_wdata,
  axil_read_if.slave                             axi
);
  import framebuf_pkg::*;

  // one word per visible pixel
  logic [fb_data_width-1:0] mem [fb_depth];

  logic ar_done;
  logic r_done;

  assign ar_done = axi.arvalid && axi.arready;
  assign r_done  = axi.rvalid && axi.rready;

  // image load port
  always_ff @(posedge clk) begin
    if (fb_we) begin
      mem[fb_waddr] <= fb_wdata;
    end
  end

  // single outstanding read
  // take a new address only once the last response has gone
  assign axi.arready = !axi.rvalid;

  // no error path, every read answers okay
  assign axi.rresp = resp_okay;

  // response valid, held until the master takes it
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      axi.rvalid <= 1'b0;
    end else begin
      if (ar_done) begin
        axi.rvalid <= 1'b1;
      end else if (r_done) begin
        axi.rvalid <= 1'b0;
      end
    end
  end

  // read word captured on the address handshake
  // stays put while rvalid waits for rready
  always_ff @(posedge clk) begin
    if (ar_done) begin
      axi.rdata <= mem[axi.araddr];
    end
  end

  // requests must land inside the framebuffer
  a_araddr_in_range : assert property (
    @(posedge clk) disable iff (reset)
    axi.arvalid |-> (int'(axi.araddr) < fb_depth)
  ) else $error("framebuf_sram: read address %0d outside framebuffer", axi.araddr);

endmodule

/* verilog/vga_sram_pixel_stream.sv */
module vga_sram_pixel_stream (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 enable,
  axil_read_if.master          axi,
  output framebuf_pkg::pixel_t pixel,
  output logic                 pixel_valid,
  input  logic                 pixel_ready
);
  import vga_timing_pkg::*;
  import framebuf_pkg::*;

  // idle    waiting to start the current position
  // fetch   memory read in flight for a visible position
  // present pixel offered to the fifo
  typedef enum logic [1:0] {
    st_idle,
    st_fetch,
    st_present
  } state_t;

  state_t state;

  // raster position
  logic [col_width-1:0] column;
  logic [row_width-1:0] row;

  logic                     visible;
  logic                     hsync_now;
  logic                     vsync_now;
  logic [fb_addr_width-1:0] pixel_addr;
  logic                     start_pos;
  logic                     read_done;
  logic                     pixel_done;
  logic                     last_col;
  logic                     last_row;

  assign visible   = (column < h_visible) && (row < v_visible);
  // sync is active low inside its window
  assign hsync_now = !((column >= h_sync_start) && (column < h_sync_end));
  assign vsync_now = !((row >= v_sync_start) && (row < v_sync_end));

  // linear framebuffer, row major
  assign pixel_addr = fb_addr_width'(row * h_visible + column);

  assign last_col = (column == col_width'(h_whole_line - 1));
  assign last_row = (row == row_width'(v_whole_frame - 1));

  // a new position only begins while enabled
  assign start_pos  = (state == st_idle) && enable;
  assign read_done  = axi.rvalid && axi.rready;
  assign pixel_done = pixel_valid && pixel_ready;

  assign pixel_valid = (state == st_present);
  // ready for the response for the whole fetch
  assign axi.rready  = (state == st_fetch);

  // fsm, raster counters and read request valid
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= st_idle;
      column      <= '0;
      row         <= '0;
      axi.arvalid <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (enable) begin
            // blanking skips memory entirely
            if (visible) begin
              axi.arvalid <= 1'b1;
              state       <= st_fetch;
            end else begin
              state <= st_present;
            end
          end
        end

        st_fetch: begin
          // hold the request until the slave takes it
          if (axi.arvalid && axi.arready) begin
            axi.arvalid <= 1'b0;
          end
          if (read_done) begin
            state <= st_present;
          end
        end

        st_present: begin
          // advance only once the fifo has the pixel
          if (pixel_done) begin
            state <= st_idle;
            if (last_col) begin
              column <= '0;
              row    <= last_row ? '0 : row + 1'b1;
            end else begin
              column <= column + 1'b1;
            end
          end
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // request address and pixel payload
  always_ff @(posedge clk) begin
    if (start_pos && visible) begin
      axi.araddr <= pixel_addr;
    end
    // blanking is black, visible takes the stored nibbles
    if ((start_pos && !visible) || read_done) begin
      pixel.red   <= read_done ? axi.rdata[red_lsb +: color_width] : '0;
      pixel.green <= read_done ? axi.rdata[green_lsb +: color_width] : '0;
      pixel.blue  <= read_done ? axi.rdata[blue_lsb +: color_width] : '0;
      pixel.hsync <= hsync_now;
      pixel.vsync <= vsync_now;
    end
  end

  // the framebuffer never reports an error
  a_rresp_okay : assert property (
    @(posedge clk) disable iff (reset)
    read_done |-> (axi.rresp == resp_okay)
  ) else $error("vga_sram_pixel_stream: read response not okay");

  // offered pixel held steady under back-pressure
  a_pixel_stable : assert property (
    @(posedge clk) disable iff (reset)
    (pixel_valid && !pixel_ready) |=> (pixel_valid && $stable(pixel))
  ) else $error("vga_sram_pixel_stream: pixel changed while stalled");

endmodule

/* verilog/pixel_fifo.sv */
module pixel_fifo #(
  parameter type item_t     = framebuf_pkg::pixel_t,
  parameter int  fifo_depth = 4
) (
  input  logic  clk,
  input  logic  reset,
  input  item_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output item_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);
  // depth is a power of two, pointers wrap by overflow
  localparam int ptr_width = $clog2(fifo_depth);

  item_t mem [fifo_depth];

  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width-1:0] wr_ptr;
  // one bit wider to hold a full count
  logic [ptr_width:0]   count;
  logic                 push;
  logic                 pop;

  assign in_ready  = (count < (ptr_width + 1)'(fifo_depth));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // pointers and occupancy, push and pop may coincide
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  a_count_bound : assert property (
    @(posedge clk) disable iff (reset)
    count <= (ptr_width + 1)'(fifo_depth)
  ) else $error("pixel_fifo: occupancy above depth");

  // an empty fifo has both pointers together
  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (reset)
    (count == '0) |-> (rd_ptr == wr_ptr)
  ) else $error("pixel_fifo: pop while empty");

endmodule

/* verilog/vga_scanout.sv */
module vga_scanout (
  input  logic                 clk,
  input  logic                 reset,
  input  framebuf_pkg::pixel_t in_pixel,
  input  logic                 in_valid,
  output logic                 in_ready,
  output logic                 hsync,
  output logic                 vsync,
  output logic [3:0]           red,
  output logic [3:0]           green,
  output logic [3:0]           blue,
  output logic                 pixel_valid
);
  import vga_timing_pkg::*;

  localparam int div_width = $clog2(scan_div);

  // pixel-rate divider
  logic [div_width-1:0] div_cnt;
  logic                 pop;

  // pop slot only on the terminal count
  assign in_ready = (div_cnt == div_width'(scan_div - 1));
  assign pop      = in_valid && in_ready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      div_cnt     <= '0;
      pixel_valid <= 1'b0;
      hsync       <= 1'b1;
      vsync       <= 1'b1;
      red         <= '0;
      green       <= '0;
      blue        <= '0;
    end else begin
      div_cnt <= in_ready ? '0 : div_cnt + 1'b1;
      // one cycle strobe per pixel, empty slot stays low
      pixel_valid <= pop;
      // all outputs move together
      if (pop) begin
        hsync <= in_pixel.hsync;
        vsync <= in_pixel.vsync;
        red   <= in_pixel.red;
        green <= in_pixel.green;
        blue  <= in_pixel.blue;
      end
    end
  end

  // output pacing, never faster than one pixel per scan_div clocks
  a_pacing : assert property (
    @(posedge clk) disable iff (reset)
    pixel_valid |=> !pixel_valid [* (scan_div - 1)]
  ) else $error("vga_scanout: output pixels closer than scan_div");

endmodule

/* verilog/vga_framebuf_top.sv */
module vga_framebuf_top (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   enable,
  input  logic                                   fb_we,
  input  logic [framebuf_pkg::fb_addr_width-1:0] fb_waddr,
  input  logic [framebuf_pkg::fb_data_width-1:0] fb_wdata,
  output logic                                   hsync,
  output logic                                   vsync,
  output logic [3:0]                             red,
  output logic [3:0]                             green,
  output logic [3:0]                             blue,
  output logic                                   pixel_valid
);
  import framebuf_pkg::*;

  // stream to fifo
  pixel_t stream_pixel;
  logic   stream_valid;
  logic   stream_ready;

  // fifo to scanout
  pixel_t fifo_pixel;
  logic   fifo_valid;
  logic   fifo_ready;

  // framebuffer read bus
  axil_read_if i_axil_read_if (
    .clk (clk)
  );

  framebuf_sram i_framebuf_sram (
    .clk      (clk),
    .reset    (reset),
    .fb_we    (fb_we),
    .fb_waddr (fb_waddr),
    .fb_wdata (fb_wdata),
    .axi      (i_axil_read_if.slave)
  );

  vga_sram_pixel_stream i_vga_sram_pixel_stream (
    .clk         (clk),
    .reset       (reset),
    .enable      (enable),
    .axi         (i_axil_read_if.master),
    .pixel       (stream_pixel),
    .pixel_valid (stream_valid),
    .pixel_ready (stream_ready)
  );

  pixel_fifo #(
    .item_t     (pixel_t),
    .fifo_depth (4)
  ) i_pixel_fifo (
    .clk       (clk),
    .reset     (reset),
    .in_data   (stream_pixel),
    .in_valid  (stream_valid),
    .in_ready  (stream_ready),
    .out_data  (fifo_pixel),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready)
  );

  vga_scanout i_vga_scanout (
    .clk         (clk),
    .reset       (reset),
    .in_pixel    (fifo_pixel),
    .in_valid    (fifo_valid),
    .in_ready    (fifo_ready),
    .hsync       (hsync),
    .vsync       (vsync),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .pixel_valid (pixel_valid)
  );

endmodule

/* test/tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int half_period_ns = 5,
  parameter int reset_cycles   = 4
) (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  // free running clock, 10 ns period by default
  initial begin
    clk = 1'b0;
    forever #(half_period_ns) clk = ~clk;
  end

  // reset held over the first few rising edges
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* test/tb_vga_framebuf.sv */
module tb_vga_framebuf;
  timeunit 1ns;
  timeprecision 1ps;
  import vga_timing_pkg::*;
  import framebuf_pkg::*;

  localparam int frame_pixels = h_whole_line * v_whole_frame;
  localparam int clk_period_ns = 10;
  // six frames at the nominal output rate plus room for the pauses
  localparam int watchdog_ns = 6 * frame_pixels * scan_div * clk_period_ns + 10000;
  // fifo depth, the stream's held pixel, the pixel on the drop edge and one spare
  localparam int drain_max = 7;
  localparam int quiet_cycles = 16;
  localparam int num_tests = 6;

  logic                     clk;
  logic                     reset;
  logic                     enable;
  logic                     fb_we;
  logic [fb_addr_width-1:0] fb_waddr;
  logic [fb_data_width-1:0] fb_wdata;
  logic                     hsync;
  logic                     vsync;
  logic [3:0]               red;
  logic [3:0]               green;
  logic [3:0]               blue;
  logic                     pixel_valid;

  integer seed = 32'h9a5f_acac;

  // reference copy of the framebuffer
  logic [fb_data_width-1:0] fb_model [fb_depth];
  // frame one as expected, for the repeat check
  logic [13:0] frame_ref [frame_pixels];

  int pix_count;
  int since_last;
  bit seen_any;
  // which test owns colour errors after frame one
  int phase;
  int errs [num_tests];
  string test_names [num_tests] = '{"first_frame", "blanking_sync", "frame_wrap",
                                    "pause", "reload", "pacing"};

  tb_clock_gen i_tb_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  vga_framebuf_top i_vga_framebuf_top (
    .clk         (clk),
    .reset       (reset),
    .enable      (enable),
    .fb_we       (fb_we),
    .fb_waddr    (fb_waddr),
    .fb_wdata    (fb_wdata),
    .hsync       (hsync),
    .vsync       (vsync),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .pixel_valid (pixel_valid)
  );

  // expected pixel from the raster index and the model memory
  task automatic check_pixel();
    int idx;
    int col;
    int row;
    int slot;
    bit vis;
    logic [fb_data_width-1:0] word;
    logic [11:0] exp_rgb;
    logic exp_hs;
    logic exp_vs;
    logic [13:0] seen;
    idx = pix_count % frame_pixels;
    col = idx % h_whole_line;
    row = idx / h_whole_line;
    vis = (col < h_visible) && (row < v_visible);
    // sync low for the pulse width right after the front porch
    exp_hs = !((col >= h_visible + h_front_porch) &&
               (col < h_visible + h_front_porch + h_sync_pulse));
    exp_vs = !((row >= v_visible + v_front_porch) &&
               (row < v_visible + v_front_porch + v_sync_pulse));
    exp_rgb = '0;
    if (vis) begin
      word = fb_model[row * h_visible + col];
      exp_rgb = {word[15:12], word[11:8], word[7:4]};
    end
    slot = (pix_count < frame_pixels) ? 0 : phase;
    seen = {red, green, blue, hsync, vsync};
    if ((hsync !== exp_hs) || (vsync !== exp_vs)) begin
      $display("error at %0t: pixel %0d col %0d row %0d sync %b%b, expected %b%b",
               $time, pix_count, col, row, hsync, vsync, exp_hs, exp_vs);
      errs[1]++;
    end
    if ({red, green, blue} !== exp_rgb) begin
      $display("error at %0t: pixel %0d col %0d row %0d colour %h, expected %h",
               $time, pix_count, col, row, {red, green, blue}, exp_rgb);
      // blanking colour belongs to the sync test
      if (vis) begin
        errs[slot]++;
      end else begin
        errs[1]++;
      end
    end
    // frame two must match frame one
    if (pix_count < frame_pixels) begin
      frame_ref[idx] = {exp_rgb, exp_hs, exp_vs};
    end else if (pix_count < 2 * frame_pixels) begin
      if (seen !== frame_ref[idx]) begin
        $display("error at %0t: frame two pixel %0d is %h, expected %h",
                 $time, idx, seen, frame_ref[idx]);
        errs[2]++;
      end
    end
    pix_count++;
  endtask

  // output monitor, sampled on the edge where outputs are settled
  always @(posedge clk) begin
    if (reset) begin
      since_last = 0;
      seen_any = 1'b0;
    end else begin
      if (pixel_valid) begin
        if (seen_any && (since_last + 1 < scan_div)) begin
          $display("error at %0t: pixel %0d only %0d cycles after the previous one",
                   $time, pix_count, since_last + 1);
          errs[5]++;
        end
        seen_any = 1'b1;
        since_last = 0;
        check_pixel();
      end else begin
        since_last++;
      end
    end
  end

  // fill the whole framebuffer with random words, model follows
  task automatic load_framebuffer();
    logic [fb_data_width-1:0] word;
    for (int a = 0; a < fb_depth; a++) begin
      word = fb_data_width'($random(seed));
      @(posedge clk);
      fb_we    <= 1'b1;
      fb_waddr <= fb_addr_width'(a);
      fb_wdata <= word;
      fb_model[a] = word;
    end
    @(posedge clk);
    fb_we <= 1'b0;
  endtask

  // counts are read on the falling edge only
  task automatic wait_pixels(input int target);
    @(negedge clk);
    while (pix_count < target) begin
      @(negedge clk);
    end
  endtask

  task automatic pause_and_drain(input bit reload);
    int at_drop;
    int quiet;
    int hold;
    int stray;
    at_drop = pix_count;
    @(posedge clk);
    enable <= 1'b0;
    // drained once the output has been idle for a while
    quiet = 0;
    while (quiet < quiet_cycles) begin
      @(negedge clk);
      quiet = pixel_valid ? 0 : quiet + 1;
    end
    if (pix_count - at_drop > drain_max) begin
      $display("error at %0t: %0d pixels after enable dropped, expected at most %0d",
               $time, pix_count - at_drop, drain_max);
      errs[phase]++;
    end
    if (reload) begin
      load_framebuffer();
    end
    // output must stay silent for the rest of the pause
    hold = 8 + ($unsigned($random(seed)) % 24);
    stray = 0;
    repeat (hold) begin
      @(negedge clk);
      if (pixel_valid) begin
        stray++;
      end
    end
    if (stray != 0) begin
      $display("error at %0t: %0d pixels emitted while paused", $time, stray);
      errs[phase]++;
    end
    @(posedge clk);
    enable <= 1'b1;
  endtask

  task automatic report_test(input int n);
    $display("test %0d %s: %s, %0d errors", n + 1, test_names[n],
             (errs[n] == 0) ? "passed" : "failed", errs[n]);
  endtask

  initial begin
    int target;
    int frame_end;
    int passed;
    enable   = 1'b0;
    fb_we    = 1'b0;
    fb_waddr = '0;
    fb_wdata = '0;
    phase    = 2;
    @(negedge reset);

    // first frame from freshly loaded data
    load_framebuffer();
    @(posedge clk);
    enable <= 1'b1;
    wait_pixels(frame_pixels);
    report_test(0);

    // second frame repeats the first
    wait_pixels(2 * frame_pixels);
    report_test(2);

    // random pause points, raster must continue seamlessly
    phase = 3;
    repeat (3) begin
      target = pix_count + 5 + ($unsigned($random(seed)) % 20);
      wait_pixels(target);
      pause_and_drain(1'b0);
    end
    report_test(3);

    // rewrite while paused, then one whole frame of new contents
    phase = 4;
    target = pix_count + 5 + ($unsigned($random(seed)) % 20);
    wait_pixels(target);
    pause_and_drain(1'b1);
    frame_end = ((pix_count + frame_pixels - 1) / frame_pixels + 1) * frame_pixels;
    wait_pixels(frame_end);
    report_test(4);

    // these two span the whole run
    report_test(1);
    report_test(5);

    passed = 0;
    for (int n = 0; n < num_tests; n++) begin
      if (errs[n] == 0) begin
        passed++;
      end
    end
    $display("summary: %0d passed, %0d failed out of %0d", passed, num_tests - passed,
             num_tests);
    if (passed == num_tests) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_ns);
    $display("run timed out after %0d ns before all tests finished", watchdog_ns);
    $display("tests failed");
    $finish;
  end

endmodule

/* vga_framebuf.f */
verilog/vga_timing_pkg.sv
verilog/framebuf_pkg.sv
verilog/axil_read_if.sv
verilog/framebuf_sram.sv
verilog/vga_sram_pixel_stream.sv
verilog/pixel_fifo.sv
verilog/vga_scanout.sv
verilog/vga_framebuf_top.sv
test/tb_clock_gen.sv
test/tb_vga_framebuf.sv

/* Bender.yml */
package:
  name: vga_framebuf

sources:
  - verilog/vga_timing_pkg.sv
  - verilog/framebuf_pkg.sv
  - verilog/axil_read_if.sv
  - verilog/framebuf_sram.sv
  - verilog/vga_sram_pixel_stream.sv
  - verilog/pixel_fifo.sv
  - verilog/vga_scanout.sv
  - verilog/vga_framebuf_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_vga_framebuf.sv
